//--- common/dma_config.svh
////////////////////////////////////////
// Build-time sizes of the DMA subsystem
// Port count and bus/field widths
////////////////////////////////////////

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Number of register control ports
`define DMA_NUM_REGS 2

// Bus and descriptor widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_LEN_W  16
`define DMA_ID_W   16

`endif

//--- common/dma_xfer_pkg.sv
////////////////////////////////////////
// Transfer descriptor types
// Copy engine FSM state encoding
////////////////////////////////////////

`include "dma_config.svh"

package dma_xfer_pkg;

  // Byte address, always word aligned
  typedef logic [`DMA_ADDR_W-1:0] addr_t;

  // Transfer length in words
  typedef logic [`DMA_LEN_W-1:0] len_t;

  // Transfer id, wraps on overflow
  typedef logic [`DMA_ID_W-1:0] tid_t;

  // One memory word
  typedef logic [`DMA_DATA_W-1:0] data_t;

  // Copy engine states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RD   = 2'd1,
    WR   = 2'd2,
    DONE = 2'd3
  } engine_state_e;

endpackage

//--- common/dma_regmap_pkg.sv
////////////////////////////////////////
// Control port register map
// Offsets, register word, status bits
////////////////////////////////////////

package dma_regmap_pkg;

  // Width of a control port word
  typedef logic [31:0] reg_word_t;

  // Byte offsets inside one register block
  typedef enum logic [7:0] {
    SRC_ADDR = 8'h00,
    DST_ADDR = 8'h04,
    LENGTH   = 8'h08,
    // Reading this one launches the transfer
    NEXT_ID  = 8'h0C,
    DONE_ID  = 8'h10,
    STATUS   = 8'h14
  } reg_offset_e;

  // STATUS fields
  localparam int unsigned STATUS_BUSY_BIT = 0;

endpackage

//--- dma_frontend/dma_reg_frontend.sv
////////////////////////////////////////
// Register front-end of one control port
// Wishbone slave, descriptor registers,
// launch on NEXT_ID read
////////////////////////////////////////

`timescale 1ns/10ps

module dma_reg_frontend (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Wishbone classic slave
  input  logic                      ctl_cyc_i,
  input  logic                      ctl_stb_i,
  input  logic                      ctl_we_i,
  input  dma_regmap_pkg::reg_word_t ctl_adr_i,
  input  dma_regmap_pkg::reg_word_t ctl_dat_i,
  output dma_regmap_pkg::reg_word_t ctl_dat_o,
  output logic                      ctl_ack_o,
  // Launch request towards the arbiter
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output dma_xfer_pkg::addr_t       src_o,
  output dma_xfer_pkg::addr_t       dst_o,
  output dma_xfer_pkg::len_t        len_o,
  // Engine status
  input  dma_xfer_pkg::tid_t        next_id_i,
  input  dma_xfer_pkg::tid_t        done_id_i,
  input  logic                      busy_i
);

  import dma_xfer_pkg::*;
  import dma_regmap_pkg::*;

  localparam int unsigned OFF_W = $bits(reg_offset_e);

  // Descriptor registers
  addr_t       src_q;
  addr_t       dst_q;
  len_t        len_q;

  // Bus handshake state
  logic        ack_q;
  logic        launch_q;
  reg_word_t   rd_q;
  reg_word_t   rd_d;

  // Decode
  logic        req_new;
  logic        adr_hit;
  logic        is_launch;
  reg_offset_e offs;

  // A request counts only once, not while its ack or launch is pending
  assign req_new = ctl_cyc_i & ctl_stb_i & ~ack_q & ~launch_q;

  // Upper address bits must be zero to hit the block
  assign adr_hit = (ctl_adr_i[$bits(reg_word_t)-1:OFF_W] == '0);
  assign offs    = reg_offset_e'(ctl_adr_i[OFF_W-1:0]);

  assign is_launch = req_new & ~ctl_we_i & adr_hit & (offs == NEXT_ID);

  // Read mux for ordinary reads
  always_comb begin
    rd_d = '0;
    if (adr_hit) begin
      case (offs)
        SRC_ADDR: rd_d = reg_word_t'(src_q);
        DST_ADDR: rd_d = reg_word_t'(dst_q);
        LENGTH:   rd_d = reg_word_t'(len_q);
        DONE_ID:  rd_d = reg_word_t'(done_id_i);
        STATUS:   rd_d[STATUS_BUSY_BIT] = busy_i;
        // NEXT_ID data comes from the launch path
        default:  rd_d = '0;
      endcase
    end
  end

  // Handshake and register writes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      launch_q <= 1'b0;
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
    end else begin
      ack_q <= 1'b0;
      if (launch_q) begin
        // Bus cycle stalls until the engine takes the descriptor
        if (req_ready_i) begin
          launch_q <= 1'b0;
          ack_q    <= 1'b1;
        end
      end else if (is_launch) begin
        launch_q <= 1'b1;
      end else if (req_new) begin
        ack_q <= 1'b1;
        // Read-only and unknown offsets fall through untouched
        if (ctl_we_i && adr_hit) begin
          case (offs)
            SRC_ADDR: src_q <= addr_t'(ctl_dat_i);
            DST_ADDR: dst_q <= addr_t'(ctl_dat_i);
            LENGTH:   len_q <= ctl_dat_i[$bits(len_t)-1:0];
            default:  ;
          endcase
        end
      end
    end
  end

  // Read data holding register
  always_ff @(posedge clk_i) begin
    if (launch_q && req_ready_i) begin
      // Id the engine assigns in this handshake
      rd_q <= reg_word_t'(next_id_i);
    end else if (req_new && !ctl_we_i) begin
      rd_q <= rd_d;
    end
  end

  assign ctl_ack_o   = ack_q;
  assign ctl_dat_o   = rd_q;

  assign req_valid_o = launch_q;
  assign src_o       = src_q;
  assign dst_o       = dst_q;
  assign len_o       = len_q;

endmodule

//--- verilog/dma_rr_arbiter.sv
////////////////////////////////////////
// Round-robin arbiter with lock-in
// Muxes the winning descriptor
////////////////////////////////////////

`timescale 1ns/10ps

`include "dma_config.svh"

module dma_rr_arbiter #(
  parameter int unsigned NUM = `DMA_NUM_REGS
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // Front-end side
  input  logic [NUM-1:0]      req_valid_i,
  output logic [NUM-1:0]      req_ready_o,
  input  dma_xfer_pkg::addr_t src_i [NUM],
  input  dma_xfer_pkg::addr_t dst_i [NUM],
  input  dma_xfer_pkg::len_t  len_i [NUM],
  // Engine side
  output logic                eng_valid_o,
  input  logic                eng_ready_i,
  output dma_xfer_pkg::addr_t eng_src_o,
  output dma_xfer_pkg::addr_t eng_dst_o,
  output dma_xfer_pkg::len_t  eng_len_o
);

  localparam int unsigned IDX_W = (NUM > 1) ? $clog2(NUM) : 1;

  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [IDX_W-1:0] sel;
  logic             any_valid;

  // Search starts just after the last winner
  always_comb begin : pick
    int unsigned cand;
    sel       = last_q;
    any_valid = 1'b0;
    for (int unsigned k = 1; k <= NUM; k++) begin
      cand = int'(last_q) + k;
      if (cand >= NUM) begin
        cand = cand - NUM;
      end
      if (!any_valid && req_valid_i[cand]) begin
        sel       = IDX_W'(cand);
        any_valid = 1'b1;
      end
    end
    // Locked grant wins while its requester stays valid
    if (lock_q && req_valid_i[lock_idx_q]) begin
      sel       = lock_idx_q;
      any_valid = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Port 0 is first in line after reset
      last_q     <= IDX_W'(NUM - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (any_valid && eng_ready_i) begin
      last_q <= sel;
      lock_q <= 1'b0;
    end else if (any_valid) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel;
    end else begin
      lock_q <= 1'b0;
    end
  end

  assign eng_valid_o = any_valid;
  assign eng_src_o   = src_i[sel];
  assign eng_dst_o   = dst_i[sel];
  assign eng_len_o   = len_i[sel];

  // Ready goes back to the winner only
  always_comb begin
    req_ready_o      = '0;
    req_ready_o[sel] = eng_ready_i & any_valid;
  end

endmodule

//--- dma_backend/dma_copy_engine.sv
////////////////////////////////////////
// Word copy engine
// Wishbone master, id counters, busy
////////////////////////////////////////

`timescale 1ns/10ps

`include "dma_config.svh"

module dma_copy_engine (
  input  logic                clk_i,
  input  logic                rst_i,
  // Descriptor from the arbiter
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  dma_xfer_pkg::addr_t src_i,
  input  dma_xfer_pkg::addr_t dst_i,
  input  dma_xfer_pkg::len_t  len_i,
  // Status to the front-ends
  output dma_xfer_pkg::tid_t  next_id_o,
  output dma_xfer_pkg::tid_t  done_id_o,
  output logic                busy_o,
  // Wishbone classic master
  output logic                mem_cyc_o,
  output logic                mem_stb_o,
  output logic                mem_we_o,
  output dma_xfer_pkg::addr_t mem_adr_o,
  output dma_xfer_pkg::data_t mem_dat_o,
  input  dma_xfer_pkg::data_t mem_dat_i,
  input  logic                mem_ack_i
);

  import dma_xfer_pkg::*;

  // Address increment per word
  localparam addr_t WORD_STEP = addr_t'(`DMA_DATA_W / 8);

  engine_state_e state_q;

  // Current transfer
  addr_t src_q;
  addr_t dst_q;
  len_t  left_q;
  data_t data_q;
  tid_t  cur_id_q;

  // Counters and flags
  tid_t  next_id_q;
  tid_t  done_id_q;
  logic  busy_q;
  logic  stb_q;

  logic  accept;
  logic  last_word;
  logic  rd_ack;
  logic  wr_ack;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i & req_ready_o;
  assign last_word   = (left_q == len_t'(1));
  assign rd_ack      = (state_q == RD) & stb_q & mem_ack_i;
  assign wr_ack      = (state_q == WR) & stb_q & mem_ack_i;

  // Bus outputs follow the state
  assign mem_cyc_o = stb_q;
  assign mem_stb_o = stb_q;
  assign mem_we_o  = (state_q == WR);
  assign mem_adr_o = (state_q == WR) ? dst_q : src_q;
  assign mem_dat_o = data_q;

  // Control FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      stb_q     <= 1'b0;
      busy_q    <= 1'b0;
      next_id_q <= tid_t'(1);
      done_id_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            next_id_q <= next_id_q + tid_t'(1);
            busy_q    <= 1'b1;
            if (len_i == '0) begin
              state_q <= DONE;
            end else begin
              state_q <= RD;
              stb_q   <= 1'b1;
            end
          end
        end
        RD: begin
          // One idle cycle between bus cycles
          if (!stb_q) begin
            stb_q <= 1'b1;
          end else if (mem_ack_i) begin
            stb_q   <= 1'b0;
            state_q <= WR;
          end
        end
        WR: begin
          if (!stb_q) begin
            stb_q <= 1'b1;
          end else if (mem_ack_i) begin
            stb_q <= 1'b0;
            if (last_word) begin
              state_q   <= DONE;
              done_id_q <= cur_id_q;
              busy_q    <= 1'b0;
            end else begin
              state_q <= RD;
            end
          end
        end
        DONE: begin
          // Zero-length transfers finish here
          done_id_q <= cur_id_q;
          busy_q    <= 1'b0;
          state_q   <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q    <= src_i;
      dst_q    <= dst_i;
      left_q   <= len_i;
      cur_id_q <= next_id_q;
    end
    if (rd_ack) begin
      data_q <= mem_dat_i;
    end
    if (wr_ack) begin
      src_q  <= src_q + WORD_STEP;
      dst_q  <= dst_q + WORD_STEP;
      left_q <= left_q - len_t'(1);
    end
  end

  assign next_id_o = next_id_q;
  assign done_id_o = done_id_q;
  assign busy_o    = busy_q;

endmodule

//--- verilog/dma_subsystem.sv
////////////////////////////////////////
// DMA subsystem top level
// Front-ends, arbiter and copy engine
////////////////////////////////////////

`timescale 1ns/10ps

`include "dma_config.svh"

module dma_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Control ports
  input  logic [`DMA_NUM_REGS-1:0]  ctl_cyc_i,
  input  logic [`DMA_NUM_REGS-1:0]  ctl_stb_i,
  input  logic [`DMA_NUM_REGS-1:0]  ctl_we_i,
  input  dma_regmap_pkg::reg_word_t ctl_adr_i [`DMA_NUM_REGS],
  input  dma_regmap_pkg::reg_word_t ctl_dat_i [`DMA_NUM_REGS],
  output dma_regmap_pkg::reg_word_t ctl_dat_o [`DMA_NUM_REGS],
  output logic [`DMA_NUM_REGS-1:0]  ctl_ack_o,
  // Memory port
  output logic                      mem_cyc_o,
  output logic                      mem_stb_o,
  output logic                      mem_we_o,
  output dma_xfer_pkg::addr_t       mem_adr_o,
  output dma_xfer_pkg::data_t       mem_dat_o,
  input  dma_xfer_pkg::data_t       mem_dat_i,
  input  logic                      mem_ack_i
);

  import dma_xfer_pkg::*;

  localparam int unsigned NUM_REGS = `DMA_NUM_REGS;

  // Front-end requests
  logic [NUM_REGS-1:0] fe_valid;
  logic [NUM_REGS-1:0] fe_ready;
  addr_t               fe_src [NUM_REGS];
  addr_t               fe_dst [NUM_REGS];
  len_t                fe_len [NUM_REGS];

  // Arbiter to engine
  logic                eng_valid;
  logic                eng_ready;
  addr_t               eng_src;
  addr_t               eng_dst;
  len_t                eng_len;

  // Engine status, shared by all ports
  tid_t                next_id;
  tid_t                done_id;
  logic                busy;

  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_frontend
    dma_reg_frontend frontend_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ctl_cyc_i   (ctl_cyc_i[i]),
      .ctl_stb_i   (ctl_stb_i[i]),
      .ctl_we_i    (ctl_we_i[i]),
      .ctl_adr_i   (ctl_adr_i[i]),
      .ctl_dat_i   (ctl_dat_i[i]),
      .ctl_dat_o   (ctl_dat_o[i]),
      .ctl_ack_o   (ctl_ack_o[i]),
      .req_valid_o (fe_valid[i]),
      .req_ready_i (fe_ready[i]),
      .src_o       (fe_src[i]),
      .dst_o       (fe_dst[i]),
      .len_o       (fe_len[i]),
      .next_id_i   (next_id),
      .done_id_i   (done_id),
      .busy_i      (busy)
    );
  end

  dma_rr_arbiter #(
    .NUM (NUM_REGS)
  ) arbiter_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (fe_valid),
    .req_ready_o (fe_ready),
    .src_i       (fe_src),
    .dst_i       (fe_dst),
    .len_i       (fe_len),
    .eng_valid_o (eng_valid),
    .eng_ready_i (eng_ready),
    .eng_src_o   (eng_src),
    .eng_dst_o   (eng_dst),
    .eng_len_o   (eng_len)
  );

  dma_copy_engine engine_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (eng_valid),
    .req_ready_o (eng_ready),
    .src_i       (eng_src),
    .dst_i       (eng_dst),
    .len_i       (eng_len),
    .next_id_o   (next_id),
    .done_id_o   (done_id),
    .busy_o      (busy),
    .mem_cyc_o   (mem_cyc_o),
    .mem_stb_o   (mem_stb_o),
    .mem_we_o    (mem_we_o),
    .mem_adr_o   (mem_adr_o),
    .mem_dat_o   (mem_dat_o),
    .mem_dat_i   (mem_dat_i),
    .mem_ack_i   (mem_ack_i)
  );

endmodule

//--- verif/dma_mem_model.sv
////////////////////////////////////////
// Wishbone classic memory model
// Word array, per-access ack delay
////////////////////////////////////////

`timescale 1ns/10ps

module dma_mem_model #(
  parameter int unsigned DEPTH = 4096
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  dma_xfer_pkg::addr_t adr_i,
  input  dma_xfer_pkg::data_t dat_i,
  output dma_xfer_pkg::data_t dat_o,
  output logic                ack_o,
  // Extra wait cycles for the next access
  input  logic [3:0]          delay_i
);

  import dma_xfer_pkg::*;

  localparam int unsigned IDX_W = $clog2(DEPTH);

  data_t            mem [DEPTH];
  logic             active_q;
  logic [3:0]       wait_q;
  logic [IDX_W-1:0] idx;

  assign idx = adr_i[IDX_W+1:2];

  // Odd multiplier keeps every address distinct
  function automatic data_t fill_word(input int unsigned i);
    addr_t a;
    a = addr_t'(i * 4);
    return (a * 32'h9E37_79B1) ^ 32'h5A3C_0F00;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      wait_q   <= '0;
      ack_o    <= 1'b0;
      for (int unsigned i = 0; i < DEPTH; i++) begin
        mem[i] <= fill_word(i);
      end
    end else begin
      ack_o <= 1'b0;
      if (active_q) begin
        if (wait_q == '0) begin
          ack_o    <= 1'b1;
          active_q <= 1'b0;
          if (we_i) begin
            mem[idx] <= dat_i;
          end else begin
            dat_o <= mem[idx];
          end
        end else begin
          wait_q <= wait_q - 4'd1;
        end
      end else if (cyc_i && stb_i && !ack_o) begin
        active_q <= 1'b1;
        wait_q   <= delay_i;
      end
    end
  end

endmodule

//--- verif/dma_tb.sv
////////////////////////////////////////
// DMA subsystem testbench
// Register bus tasks, copy checks,
// round-robin order, watchdog
////////////////////////////////////////

`timescale 1ns/10ps

`include "dma_config.svh"

module dma_tb;

  import dma_xfer_pkg::*;
  import dma_regmap_pkg::*;

  localparam int unsigned NUM_REGS   = `DMA_NUM_REGS;
  localparam int unsigned MEM_WORDS  = 4096;
  localparam int unsigned HALF       = MEM_WORDS / 2;
  localparam int unsigned SLOT       = HALF / NUM_REGS;
  localparam int unsigned MAX_LEN    = 16;
  localparam int unsigned MAX_DELAY  = 7;
  localparam int unsigned NUM_RANDOM = 20;
  // Single, two pairs, rotate, zero length and the random copies
  localparam int unsigned NUM_XFERS  = 7 + NUM_RANDOM;
  localparam int unsigned XFER_CYCLES = MAX_LEN * 2 * (MAX_DELAY + 3) + 200;
  localparam int unsigned TIMEOUT_CYCLES = NUM_XFERS * XFER_CYCLES + 2000;

  logic                clk;
  logic                rst;
  logic [NUM_REGS-1:0] ctl_cyc;
  logic [NUM_REGS-1:0] ctl_stb;
  logic [NUM_REGS-1:0] ctl_we;
  logic [NUM_REGS-1:0] ctl_ack;
  reg_word_t           ctl_adr  [NUM_REGS];
  reg_word_t           ctl_wdat [NUM_REGS];
  reg_word_t           ctl_rdat [NUM_REGS];
  logic                mem_cyc;
  logic                mem_stb;
  logic                mem_we;
  logic                mem_ack;
  addr_t               mem_adr;
  data_t               mem_wdat;
  data_t               mem_rdat;
  logic [3:0]          mem_delay = '0;

  int                  check_count = 0;
  int                  error_count = 0;
  int                  mem_active_cycles = 0;
  int                  mem_write_count = 0;
  logic [31:0]         stim_rng = 32'd51;
  logic [31:0]         delay_rng = 32'd51;
  tid_t                exp_id;
  // Round-robin model, last granted port
  int                  last_port;

  dma_subsystem dma_subsystem_inst (
    .clk_i     (clk),
    .rst_i     (rst),
    .ctl_cyc_i (ctl_cyc),
    .ctl_stb_i (ctl_stb),
    .ctl_we_i  (ctl_we),
    .ctl_adr_i (ctl_adr),
    .ctl_dat_i (ctl_wdat),
    .ctl_dat_o (ctl_rdat),
    .ctl_ack_o (ctl_ack),
    .mem_cyc_o (mem_cyc),
    .mem_stb_o (mem_stb),
    .mem_we_o  (mem_we),
    .mem_adr_o (mem_adr),
    .mem_dat_o (mem_wdat),
    .mem_dat_i (mem_rdat),
    .mem_ack_i (mem_ack)
  );

  dma_mem_model #(
    .DEPTH (MEM_WORDS)
  ) mem_inst (
    .clk_i   (clk),
    .rst_i   (rst),
    .cyc_i   (mem_cyc),
    .stb_i   (mem_stb),
    .we_i    (mem_we),
    .adr_i   (mem_adr),
    .dat_i   (mem_wdat),
    .dat_o   (mem_rdat),
    .ack_o   (mem_ack),
    .delay_i (mem_delay)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  // Sources live in the lower half, each port has its own destination slot
  function automatic addr_t random_src();
    return addr_t'((next_random() % (HALF - MAX_LEN)) * 4);
  endfunction

  function automatic addr_t random_dst(input int port);
    return addr_t'((HALF + port * SLOT + next_random() % (SLOT - MAX_LEN)) * 4);
  endfunction

  // New ack delay every cycle, 0 to MAX_DELAY
  always @(posedge clk) begin
    delay_rng = xorshift32(delay_rng);
    mem_delay <= {1'b0, delay_rng[2:0]};
  end

  always @(posedge clk) begin
    if (mem_cyc) begin
      mem_active_cycles <= mem_active_cycles + 1;
    end
    if (mem_cyc && mem_stb && mem_we && mem_ack) begin
      mem_write_count <= mem_write_count + 1;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, a bus cycle or transfer never completed",
             TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
    end
  endtask

  // One Wishbone classic cycle on a control port
  task automatic bus_cycle(input int port, input logic we, input reg_word_t adr,
                           input reg_word_t wdata, output reg_word_t rdata);
    @(posedge clk);
    ctl_cyc[port]  <= 1'b1;
    ctl_stb[port]  <= 1'b1;
    ctl_we[port]   <= we;
    ctl_adr[port]  <= adr;
    ctl_wdat[port] <= wdata;
    do @(posedge clk); while (ctl_ack[port] !== 1'b1);
    rdata = ctl_rdat[port];
    ctl_cyc[port] <= 1'b0;
    ctl_stb[port] <= 1'b0;
    ctl_we[port]  <= 1'b0;
  endtask

  task automatic write_reg(input int port, input reg_offset_e off, input reg_word_t data);
    reg_word_t rdata;
    bus_cycle(port, 1'b1, reg_word_t'(off), data, rdata);
  endtask

  task automatic read_reg(input int port, input reg_offset_e off, output reg_word_t data);
    bus_cycle(port, 1'b0, reg_word_t'(off), '0, data);
  endtask

  task automatic set_descriptor(input int port, input addr_t src, input addr_t dst,
                                input len_t len);
    write_reg(port, SRC_ADDR, reg_word_t'(src));
    write_reg(port, DST_ADDR, reg_word_t'(dst));
    write_reg(port, LENGTH, reg_word_t'(len));
  endtask

  // Poll DONE_ID, then busy must already be low
  task automatic wait_done(input string name, input int port, input tid_t id);
    reg_word_t v;
    do read_reg(port, DONE_ID, v); while (v !== reg_word_t'(id));
    read_reg(port, STATUS, v);
    check_value({name, " busy"}, 32'd0, {31'd0, v[STATUS_BUSY_BIT]});
  endtask

  task automatic check_copy(input string name, input addr_t src, input addr_t dst,
                            input len_t len);
    for (int k = 0; k < int'(len); k++) begin
      check_value($sformatf("%s word %0d", name, k),
                  mem_inst.mem[(src >> 2) + k], mem_inst.mem[(dst >> 2) + k]);
    end
  endtask

  task automatic run_copy(input string name, input int port, input addr_t src,
                          input addr_t dst, input len_t len);
    reg_word_t id;
    tid_t      my_id;
    set_descriptor(port, src, dst, len);
    my_id = exp_id;
    read_reg(port, NEXT_ID, id);
    check_value({name, " id"}, reg_word_t'(my_id), id);
    exp_id    = exp_id + tid_t'(1);
    last_port = port;
    wait_done(name, port, my_id);
    check_copy(name, src, dst, len);
  endtask

  // Both ports launch in the same cycle, the winner is read from the returned ids
  task automatic run_pair(input string name, output int winner);
    addr_t     src0;
    addr_t     src1;
    addr_t     dst0;
    addr_t     dst1;
    len_t      len0;
    len_t      len1;
    reg_word_t id0;
    reg_word_t id1;
    tid_t      win_id;
    int        exp_winner;
    src0 = random_src();
    dst0 = random_dst(0);
    len0 = len_t'(1 + next_random() % MAX_LEN);
    src1 = random_src();
    dst1 = random_dst(1);
    len1 = len_t'(1 + next_random() % MAX_LEN);
    set_descriptor(0, src0, dst0, len0);
    set_descriptor(1, src1, dst1, len1);
    exp_winner = (last_port + 1) % NUM_REGS;
    win_id     = exp_id;
    fork
      read_reg(0, NEXT_ID, id0);
      read_reg(1, NEXT_ID, id1);
    join
    check_value({name, " port 0 id"},
                reg_word_t'(exp_winner == 0 ? win_id : win_id + tid_t'(1)), id0);
    check_value({name, " port 1 id"},
                reg_word_t'(exp_winner == 1 ? win_id : win_id + tid_t'(1)), id1);
    winner    = (id0 == reg_word_t'(win_id)) ? 0 : 1;
    exp_id    = exp_id + tid_t'(2);
    last_port = 1 - exp_winner;
    wait_done(name, last_port, win_id + tid_t'(1));
    check_copy({name, " port 0"}, src0, dst0, len0);
    check_copy({name, " port 1"}, src1, dst1, len1);
  endtask

  initial begin
    reg_word_t v;
    reg_word_t pat;
    int        win_a;
    int        win_b;
    int        writes_before;
    rst     = 1'b1;
    ctl_cyc = '0;
    ctl_stb = '0;
    ctl_we  = '0;
    for (int p = 0; p < NUM_REGS; p++) begin
      ctl_adr[p]  = '0;
      ctl_wdat[p] = '0;
    end
    exp_id    = tid_t'(1);
    last_port = NUM_REGS - 1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Status after reset
    for (int p = 0; p < NUM_REGS; p++) begin
      read_reg(p, DONE_ID, v);
      check_value($sformatf("reset done id port %0d", p), 32'd0, v);
      read_reg(p, STATUS, v);
      check_value($sformatf("reset busy port %0d", p), 32'd0, v);
    end

    // Descriptor registers read back, DONE_ID is read-only
    for (int p = 0; p < NUM_REGS; p++) begin
      pat = next_random();
      write_reg(p, SRC_ADDR, pat);
      read_reg(p, SRC_ADDR, v);
      check_value($sformatf("src readback port %0d", p), pat, v);
      pat = next_random();
      write_reg(p, DST_ADDR, pat);
      read_reg(p, DST_ADDR, v);
      check_value($sformatf("dst readback port %0d", p), pat, v);
      pat = next_random() & 32'h0000_FFFF;
      write_reg(p, LENGTH, pat);
      read_reg(p, LENGTH, v);
      check_value($sformatf("length readback port %0d", p), pat, v);
      write_reg(p, DONE_ID, 32'hFFFF_FFFF);
      read_reg(p, DONE_ID, v);
      check_value($sformatf("done id write port %0d", p), 32'd0, v);
    end

    check_value("memory idle before launch", 32'd0, mem_active_cycles);
    run_copy("single copy", 0, random_src(), random_dst(0), len_t'(8));

    // Pointer rotation by a single launch flips the next pair order
    run_pair("pair A", win_a);
    run_copy("rotate", win_a, random_src(), random_dst(win_a), len_t'(2));
    run_pair("pair B", win_b);
    check_value("pair B winner", 32'(1 - win_a), 32'(win_b));

    writes_before = mem_write_count;
    run_copy("zero length", 1, random_src(), random_dst(1), len_t'(0));
    check_value("zero length writes", 32'(writes_before), 32'(mem_write_count));

    for (int i = 0; i < NUM_RANDOM; i++) begin
      run_copy($sformatf("random copy %0d", i), i % NUM_REGS, random_src(),
               random_dst(i % NUM_REGS), len_t'(1 + next_random() % MAX_LEN));
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- dma_sub.f
+incdir+common
common/dma_xfer_pkg.sv
common/dma_regmap_pkg.sv
dma_frontend/dma_reg_frontend.sv
verilog/dma_rr_arbiter.sv
dma_backend/dma_copy_engine.sv
verilog/dma_subsystem.sv
verif/dma_mem_model.sv
verif/dma_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f dma_sub.f --top-module dma_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vdma_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^STATUS: PASS$'; then
  exit 0
fi
exit 1
